// ==== alert_pkg.sv ====
// wire pairs idle at p low and n high; the enum literals of both endpoints share this scope
package alert_pkg;

  ////////////////////////////////////////
  // wire level types
  ////////////////////////////////////////

  // one differential pair as it travels between the endpoints
  // a valid pair always has p and n complementary
  typedef struct packed {
    logic p;
    logic n;
  } diff_pair_t;

  // decoded view of one pair
  // level is the logical value carried on p
  // rise and fall are single-cycle strobes and evt is their or
  // sigint stays high for as long as both wires hold the same value
  typedef struct packed {
    logic level;
    logic rise;
    logic fall;
    logic evt;
    logic sigint;
  } diff_dec_t;

  ////////////////////////////////////////
  // state machines
  ////////////////////////////////////////

  // sender handshake
  // literals carry a prefix so they do not clash with the receiver states
  typedef enum logic [1:0] {
    SndIdle,
    SndWaitAckHi,
    SndWaitAckLo
  } sender_state_e;

  // receiver handshake
  typedef enum logic {
    RcvIdle,
    RcvAcking
  } receiver_state_e;

  // pair integrity tracking inside the decoder
  typedef enum logic [1:0] {
    IsStd,
    IsSkewed,
    SigInt
  } decode_state_e;

endpackage

// ==== flop_2sync.sv ====
// single-bit two-flop synchronizer; the reset value must match the idle level of its wire
module flop_2sync #(
  // level both stages take in reset
  parameter logic ResetValue = 1'b0
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic d_i,
  output logic q_o
);

  // first stage may go metastable
  // the second stage gives it a full cycle to settle
  logic stage1_q;
  logic stage2_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage1_q <= ResetValue;
      stage2_q <= ResetValue;
    end else begin
      stage1_q <= d_i;
      stage2_q <= stage1_q;
    end
  end

  // resynchronized copy of d_i
  // two cycles behind the pin
  assign q_o = stage2_q;

endmodule

// ==== diff_decode.sv ====
// with AsyncOn the outputs trail the pins by two cycles and tolerate one cycle of wire skew
module diff_decode #(
  // 1 resynchronizes the pair and accepts one skewed cycle
  // 0 samples the pins directly and faults on any equal cycle
  parameter bit AsyncOn = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  alert_pkg::diff_pair_t pair_i,
  output alert_pkg::diff_dec_t  dec_o
);

  import alert_pkg::*;

  // local copy of the pair after the optional synchronizer
  logic sync_p;
  logic sync_n;
  // previous sample for edge detection
  logic p_q;
  logic n_q;
  logic p_edge;
  logic n_edge;
  logic pair_ok;
  // decoded level and the strobes derived from it
  logic level_d;
  logic level_q;
  logic report;
  logic rise;
  logic fall;
  logic sigint;
  decode_state_e state_d;
  decode_state_e state_q;

  ////////////////////////////////////////
  // input stage
  ////////////////////////////////////////

  if (AsyncOn) begin : gen_sync
    // p idles low
    flop_2sync #(
      .ResetValue(1'b0)
    ) u_sync_p (
      .clk_i (clk_i),
      .rst_ni(rst_ni),
      .d_i   (pair_i.p),
      .q_o   (sync_p)
    );

    // n idles high so an idle pair looks clean right out of reset
    flop_2sync #(
      .ResetValue(1'b1)
    ) u_sync_n (
      .clk_i (clk_i),
      .rst_ni(rst_ni),
      .d_i   (pair_i.n),
      .q_o   (sync_n)
    );
  end else begin : gen_direct
    // same clock on both sides
    assign sync_p = pair_i.p;
    assign sync_n = pair_i.n;
  end

  // a wire moved since last cycle
  assign p_edge = sync_p ^ p_q;
  assign n_edge = sync_n ^ n_q;
  // pair is correctly encoded
  assign pair_ok = sync_p ^ sync_n;

  ////////////////////////////////////////
  // integrity FSM
  ////////////////////////////////////////

  // a single wire change is allowed to lead its partner by one cycle
  // a second equal cycle is a fault
  always_comb begin
    state_d = state_q;
    level_d = level_q;
    report  = 1'b0;
    sigint  = 1'b0;

    unique case (state_q)
      IsStd: begin
        if (pair_ok) begin
          level_d = sync_p;
          report  = 1'b1;
        end else if (AsyncOn && (p_edge || n_edge)) begin
          // one wire moved first
          // wait one cycle for the other one
          state_d = IsSkewed;
        end else begin
          state_d = SigInt;
          sigint  = 1'b1;
        end
      end
      IsSkewed: begin
        if (pair_ok) begin
          // partner caught up
          // also covers a wire that glitched and came back
          state_d = IsStd;
          level_d = sync_p;
          report  = 1'b1;
        end else begin
          state_d = SigInt;
          sigint  = 1'b1;
        end
      end
      SigInt: begin
        if (pair_ok) begin
          // pick up the new level silently
          // an edge across a fault cannot be trusted
          state_d = IsStd;
          level_d = sync_p;
        end else begin
          sigint = 1'b1;
        end
      end
      default: begin
        state_d = IsStd;
      end
    endcase
  end

  // strobes only on an accepted level change
  assign rise = report & level_d & ~level_q;
  assign fall = report & ~level_d & level_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IsStd;
      p_q     <= 1'b0;
      n_q     <= 1'b1;
      level_q <= 1'b0;
    end else begin
      state_q <= state_d;
      p_q     <= sync_p;
      n_q     <= sync_n;
      level_q <= level_d;
    end
  end

  assign dec_o = '{
    level:  level_d,
    rise:   rise,
    fall:   fall,
    evt:    rise | fall,
    sigint: sigint
  };

endmodule

// ==== alert_sender.sv ====
// requests arriving while a handshake runs merge into one pending handshake
module alert_sender #(
  // passed to the ack pair decoder
  parameter bit AsyncOn = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // one-cycle request strobe
  input  logic                  alert_req_i,
  // ack pair from the receiver
  input  alert_pkg::diff_pair_t ack_pair_i,
  // alert pair towards the receiver
  output alert_pkg::diff_pair_t alert_pair_o,
  // handshake finished
  output logic                  alert_ack_o,
  // ack pair fault level
  output logic                  ack_sigint_o
);

  import alert_pkg::*;

  diff_dec_t     ack_dec;
  sender_state_e state_d;
  sender_state_e state_q;
  logic          pending_d;
  logic          pending_q;
  // logical alert level before differential encoding
  logic          alert_level_d;
  logic          alert_level_q;

  diff_decode #(
    .AsyncOn(AsyncOn)
  ) u_ack_decode (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .pair_i(ack_pair_i),
    .dec_o (ack_dec)
  );

  ////////////////////////////////////////
  // handshake FSM
  ////////////////////////////////////////

  // moves on the decoded ack level only
  // during a fault the decoder holds the level so the FSM sits still
  always_comb begin
    state_d       = state_q;
    pending_d     = pending_q;
    alert_level_d = alert_level_q;
    alert_ack_o   = 1'b0;

    // remember requests that land mid handshake
    if (alert_req_i && (state_q != SndIdle)) begin
      pending_d = 1'b1;
    end

    unique case (state_q)
      SndIdle: begin
        if (alert_req_i || pending_q) begin
          state_d       = SndWaitAckHi;
          alert_level_d = 1'b1;
          pending_d     = 1'b0;
        end
      end
      SndWaitAckHi: begin
        // receiver has seen the alert
        if (ack_dec.level && !ack_dec.sigint) begin
          state_d       = SndWaitAckLo;
          alert_level_d = 1'b0;
        end
      end
      SndWaitAckLo: begin
        // receiver has seen the alert drop
        if (!ack_dec.level && !ack_dec.sigint) begin
          state_d     = SndIdle;
          alert_ack_o = 1'b1;
        end
      end
      default: begin
        state_d       = SndIdle;
        alert_level_d = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= SndIdle;
      pending_q     <= 1'b0;
      alert_level_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      pending_q     <= pending_d;
      alert_level_q <= alert_level_d;
    end
  end

  // both wires come straight from one flop
  assign alert_pair_o = '{p: alert_level_q, n: ~alert_level_q};
  assign ack_sigint_o = ack_dec.sigint;

endmodule

// ==== alert_receiver.sv ====
// alert_o fires once per handshake; a fault on the alert pair freezes the ack level
module alert_receiver #(
  // passed to the alert pair decoder
  parameter bit AsyncOn = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // alert pair from the sender
  input  alert_pkg::diff_pair_t alert_pair_i,
  // ack pair towards the sender
  output alert_pkg::diff_pair_t ack_pair_o,
  // one pulse per received alert
  output logic                  alert_o,
  // alert pair fault level
  output logic                  alert_sigint_o
);

  import alert_pkg::*;

  diff_dec_t       alert_dec;
  receiver_state_e state_d;
  receiver_state_e state_q;
  // logical ack level before differential encoding
  logic            ack_level_d;
  logic            ack_level_q;

  diff_decode #(
    .AsyncOn(AsyncOn)
  ) u_alert_decode (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .pair_i(alert_pair_i),
    .dec_o (alert_dec)
  );

  ////////////////////////////////////////
  // ack FSM
  ////////////////////////////////////////

  // edges never show up during sigint
  // so a fault leaves state and ack level as they were
  always_comb begin
    state_d     = state_q;
    ack_level_d = ack_level_q;
    alert_o     = 1'b0;

    unique case (state_q)
      RcvIdle: begin
        // new alert
        if (alert_dec.rise) begin
          state_d     = RcvAcking;
          ack_level_d = 1'b1;
          alert_o     = 1'b1;
        end
      end
      RcvAcking: begin
        // sender dropped its alert
        // release the ack to close the handshake
        if (alert_dec.fall) begin
          state_d     = RcvIdle;
          ack_level_d = 1'b0;
        end
      end
      default: begin
        state_d     = RcvIdle;
        ack_level_d = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= RcvIdle;
      ack_level_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      ack_level_q <= ack_level_d;
    end
  end

  // complementary drive from one flop
  assign ack_pair_o     = '{p: ack_level_q, n: ~ack_level_q};
  assign alert_sigint_o = alert_dec.sigint;

endmodule

// ==== alert_link.sv ====
// the tx pairs are not looped inside; whatever drives the rx pins decides what each side sees
module alert_link #(
  // resynchronize both pairs
  parameter bit AsyncOn = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // request strobe into the sender
  input  logic                  alert_req_i,
  // alert pair as it arrives at the receiver
  input  alert_pkg::diff_pair_t alert_rx_i,
  // ack pair as it arrives at the sender
  input  alert_pkg::diff_pair_t ack_rx_i,
  // alert pair driven by the sender
  output alert_pkg::diff_pair_t alert_tx_o,
  // ack pair driven by the receiver
  output alert_pkg::diff_pair_t ack_tx_o,
  // handshake done on the sender side
  output logic                  alert_ack_o,
  // alert seen on the receiver side
  output logic                  alert_o,
  output logic                  alert_sigint_o,
  output logic                  ack_sigint_o
);

  ////////////////////////////////////////
  // sender side
  ////////////////////////////////////////

  alert_sender #(
    .AsyncOn(AsyncOn)
  ) u_sender (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .alert_req_i (alert_req_i),
    .ack_pair_i  (ack_rx_i),
    .alert_pair_o(alert_tx_o),
    .alert_ack_o (alert_ack_o),
    .ack_sigint_o(ack_sigint_o)
  );

  ////////////////////////////////////////
  // receiver side
  ////////////////////////////////////////

  alert_receiver #(
    .AsyncOn(AsyncOn)
  ) u_receiver (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .alert_pair_i  (alert_rx_i),
    .ack_pair_o    (ack_tx_o),
    .alert_o       (alert_o),
    .alert_sigint_o(alert_sigint_o)
  );

endmodule

// ==== tb_alert_link.sv ====
// runs with AsyncOn at 1 only; the wire model can delay an n wire one cycle or force a pair high
module tb_alert_link;

  import alert_pkg::*;

  // longest test stays well below this
  localparam int TestCycles = 150;
  // six tests with double margin
  localparam int MaxCycles  = 6 * TestCycles * 2 + 200;
  localparam diff_pair_t IdlePair = '{p: 1'b0, n: 1'b1};
  localparam diff_pair_t HighPair = '{p: 1'b1, n: 1'b0};

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       alert_req_i;
  diff_pair_t alert_tx;
  diff_pair_t ack_tx;
  diff_pair_t alert_rx;
  diff_pair_t ack_rx;
  logic       alert_ack_o;
  logic       alert_o;
  logic       alert_sigint_o;
  logic       ack_sigint_o;

  // wire model controls
  logic alert_skew;
  logic ack_skew;
  logic alert_fault;
  logic ack_fault;
  logic alert_n_dly = 1'b1;
  logic ack_n_dly   = 1'b1;

  // monitor counts only grow
  // tests compare against a snapshot
  int cycle_cnt     = 0;
  int alert_cnt     = 0;
  int ack_cnt       = 0;
  int alert_sig_cyc = 0;
  int ack_sig_cyc   = 0;
  int err_cnt;
  int check_cnt;
  int test_cnt;
  int seed;

  alert_link #(
    .AsyncOn(1'b1)
  ) dut0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .alert_req_i   (alert_req_i),
    .alert_rx_i    (alert_rx),
    .ack_rx_i      (ack_rx),
    .alert_tx_o    (alert_tx),
    .ack_tx_o      (ack_tx),
    .alert_ack_o   (alert_ack_o),
    .alert_o       (alert_o),
    .alert_sigint_o(alert_sigint_o),
    .ack_sigint_o  (ack_sigint_o)
  );

  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////
  // wire model
  ////////////////////////////////////////

  // one cycle late copy of each n wire
  always @(posedge clk_i) begin
    alert_n_dly <= alert_tx.n;
    ack_n_dly   <= ack_tx.n;
  end

  // fault wins over skew
  always_comb begin
    alert_rx = alert_tx;
    ack_rx   = ack_tx;
    if (alert_skew) alert_rx.n = alert_n_dly;
    if (ack_skew) ack_rx.n = ack_n_dly;
    if (alert_fault) alert_rx = '{p: 1'b1, n: 1'b1};
    if (ack_fault) ack_rx = '{p: 1'b1, n: 1'b1};
  end

  ////////////////////////////////////////
  // monitors and run limit
  ////////////////////////////////////////

  // values seen here are the ones held over the past cycle
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (alert_o) alert_cnt++;
      if (alert_ack_o) ack_cnt++;
      if (alert_sigint_o) alert_sig_cyc++;
      if (ack_sigint_o) ack_sig_cyc++;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= MaxCycles) begin
      $display("timeout: the run went past %0d cycles", MaxCycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////
  // compare and helper tasks
  ////////////////////////////////////////

  task automatic check_pair(input string name, input diff_pair_t exp, input diff_pair_t act);
    check_cnt++;
    if (act !== exp) begin
      $display("ERR %0t %s exp=%b act=%b", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      $display("ERR %0t %s exp=%b act=%b", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    check_cnt++;
    if (act != exp) begin
      $display("ERR %0t %s exp=%0d act=%0d", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  // one-cycle request
  task automatic strobe_request();
    @(negedge clk_i);
    alert_req_i = 1'b1;
    @(negedge clk_i);
    alert_req_i = 1'b0;
  endtask

  // ack_side selects alert_ack_o pulses, else alert_o pulses
  task automatic wait_for_pulses(input bit ack_side, input int target, input int bound);
    int n;
    n = 0;
    while ((ack_side ? ack_cnt : alert_cnt) < target && n < bound) begin
      @(negedge clk_i);
      n++;
    end
    if ((ack_side ? ack_cnt : alert_cnt) < target) begin
      $display("%0t: %s pulse number %0d did not come within %0d cycles", $time,
               ack_side ? "alert_ack_o" : "alert_o", target, bound);
      err_cnt++;
    end
  endtask

  task automatic wait_for_sigint(input bit ack_side, input logic value, input int bound);
    int   n;
    logic cur;
    n   = 0;
    cur = ack_side ? ack_sigint_o : alert_sigint_o;
    while (cur !== value && n < bound) begin
      @(negedge clk_i);
      n++;
      cur = ack_side ? ack_sigint_o : alert_sigint_o;
    end
    if (cur !== value) begin
      $display("%0t: %s did not go to %b within %0d cycles", $time,
               ack_side ? "ack_sigint_o" : "alert_sigint_o", value, bound);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, err_cnt - errs_before);
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_reset_state();
    int e0;
    e0 = err_cnt;
    check_pair("alert_tx_o", IdlePair, alert_tx);
    check_pair("ack_tx_o", IdlePair, ack_tx);
    check_bit("alert_o", 1'b0, alert_o);
    check_bit("alert_ack_o", 1'b0, alert_ack_o);
    check_bit("alert_sigint_o", 1'b0, alert_sigint_o);
    check_bit("ack_sigint_o", 1'b0, ack_sigint_o);
    report_test("reset_state", e0);
  endtask

  task automatic test_single_alert();
    int e0;
    int a0;
    int k0;
    int s0;
    int t0;
    e0 = err_cnt;
    a0 = alert_cnt;
    k0 = ack_cnt;
    s0 = alert_sig_cyc;
    t0 = ack_sig_cyc;
    strobe_request();
    wait_for_pulses(1'b0, a0 + 1, TestCycles);
    // receiver fires before the sender finishes
    check_count("alert_ack_o pulses", k0, ack_cnt);
    wait_for_pulses(1'b1, k0 + 1, TestCycles);
    idle_cycles(20);
    check_count("alert_o pulses", a0 + 1, alert_cnt);
    check_count("alert_ack_o pulses", k0 + 1, ack_cnt);
    check_count("alert_sigint_o cycles", s0, alert_sig_cyc);
    check_count("ack_sigint_o cycles", t0, ack_sig_cyc);
    check_pair("alert_tx_o", IdlePair, alert_tx);
    check_pair("ack_tx_o", IdlePair, ack_tx);
    report_test("single_alert", e0);
  endtask

  task automatic test_busy_requests();
    int e0;
    int a0;
    int k0;
    int gap;
    e0  = err_cnt;
    a0  = alert_cnt;
    k0  = ack_cnt;
    // both extra strobes land well inside the first handshake
    gap = 1 + ($unsigned($random(seed)) % 3);
    strobe_request();
    idle_cycles(gap);
    strobe_request();
    idle_cycles(gap);
    strobe_request();
    wait_for_pulses(1'b1, k0 + 2, 2 * TestCycles);
    idle_cycles(30);
    check_count("alert_o pulses", a0 + 2, alert_cnt);
    check_count("alert_ack_o pulses", k0 + 2, ack_cnt);
    check_pair("alert_tx_o", IdlePair, alert_tx);
    report_test("busy_requests", e0);
  endtask

  task automatic test_skewed_pair();
    int e0;
    int a0;
    int k0;
    int s0;
    int t0;
    e0 = err_cnt;
    a0 = alert_cnt;
    k0 = ack_cnt;
    s0 = alert_sig_cyc;
    t0 = ack_sig_cyc;
    @(negedge clk_i);
    // both pairs run with the n wire one cycle late
    alert_skew = 1'b1;
    ack_skew   = 1'b1;
    strobe_request();
    wait_for_pulses(1'b1, k0 + 1, TestCycles);
    idle_cycles(10);
    alert_skew = 1'b0;
    ack_skew   = 1'b0;
    check_count("alert_o pulses", a0 + 1, alert_cnt);
    check_count("alert_sigint_o cycles", s0, alert_sig_cyc);
    check_count("ack_sigint_o cycles", t0, ack_sig_cyc);
    report_test("skewed_pair", e0);
  endtask

  task automatic test_alert_fault();
    int e0;
    int a0;
    int k0;
    e0 = err_cnt;
    a0 = alert_cnt;
    k0 = ack_cnt;
    @(negedge clk_i);
    alert_fault = 1'b1;
    wait_for_sigint(1'b0, 1'b1, 20);
    idle_cycles(8);
    check_bit("alert_sigint_o", 1'b1, alert_sigint_o);
    check_count("alert_o pulses", a0, alert_cnt);
    // receiver keeps its ack idle
    check_pair("ack_tx_o", IdlePair, ack_tx);
    alert_fault = 1'b0;
    wait_for_sigint(1'b0, 1'b0, 20);
    idle_cycles(4);
    check_count("alert_o pulses", a0, alert_cnt);
    strobe_request();
    wait_for_pulses(1'b1, k0 + 1, TestCycles);
    check_count("alert_o pulses", a0 + 1, alert_cnt);
    check_pair("alert_tx_o", IdlePair, alert_tx);
    report_test("alert_fault", e0);
  endtask

  task automatic test_ack_fault();
    int e0;
    int a0;
    int k0;
    e0 = err_cnt;
    a0 = alert_cnt;
    k0 = ack_cnt;
    @(negedge clk_i);
    ack_fault = 1'b1;
    wait_for_sigint(1'b1, 1'b1, 20);
    strobe_request();
    // alert direction is clean so the receiver still answers
    wait_for_pulses(1'b0, a0 + 1, TestCycles);
    idle_cycles(12);
    check_bit("ack_sigint_o", 1'b1, ack_sigint_o);
    check_count("alert_ack_o pulses", k0, ack_cnt);
    check_pair("alert_tx_o", HighPair, alert_tx);
    ack_fault = 1'b0;
    wait_for_pulses(1'b1, k0 + 1, TestCycles);
    idle_cycles(10);
    check_bit("ack_sigint_o", 1'b0, ack_sigint_o);
    check_count("alert_ack_o pulses", k0 + 1, ack_cnt);
    check_count("alert_o pulses", a0 + 1, alert_cnt);
    check_pair("alert_tx_o", IdlePair, alert_tx);
    check_pair("ack_tx_o", IdlePair, ack_tx);
    report_test("ack_fault", e0);
  endtask

  ////////////////////////////////////////
  // sequence
  ////////////////////////////////////////

  initial begin
    rst_ni      = 1'b0;
    alert_req_i = 1'b0;
    alert_skew  = 1'b0;
    ack_skew    = 1'b0;
    alert_fault = 1'b0;
    ack_fault   = 1'b0;
    err_cnt     = 0;
    check_cnt   = 0;
    test_cnt    = 0;
    seed        = 72;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset_state();
    test_single_alert();
    test_busy_requests();
    test_skewed_pair();
    test_alert_fault();
    test_ack_fault();
    $display("done: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== build.f ====
alert_pkg.sv
flop_2sync.sv
diff_decode.sv
alert_sender.sv
alert_receiver.sv
alert_link.sv
tb_alert_link.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the alert link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_alert_link -f build.f -o sim_alert_link
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_alert_link > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF "*** PASSED ***" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
